//--- sim/backend_tests.txt
# op (N none, R random none, L load, S store) rd reg_write result_or_byte_addr store_data
# last column: expected register value in hex, or - when not checked
N 01 1 00000011 00000000 00000011
N 02 1 00000022 00000000 00000022
N 03 1 00000033 00000000 00000033
N 04 1 00000044 00000000 00000044
N 00 1 deadbeef 00000000 -
N 05 0 12345678 00000000 -
S 06 1 00000040 cafef00d -
L 07 1 00000040 00000000 cafef00d
R 08 1 00000000 00000000 -
R 09 1 00000000 00000000 -
R 0a 1 00000000 00000000 -
S 00 0 00000080 01020304 -
L 0b 1 00000080 00000000 01020304
L 00 1 00000040 00000000 cafef00d
N 01 1 00000099 00000000 00000099
R 1f 1 00000000 00000000 -
S 0c 0 000003fc 0badc0de -
L 1e 1 000003fc 00000000 0badc0de
N 0d 1 abcdef01 00000000 abcdef01

//--- list.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/mem_ctrl_pkg.sv
logic/stage_if.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/writeback.sv
logic/reg_file.sv
logic/backend_top.sv
sim/backend_chk.sv
sim/backend_tb.sv

//--- Bender.yml
package:
  name: backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_types_pkg.sv
      - logic/mem_ctrl_pkg.sv
      - logic/stage_if.sv
      - logic/mem_stage.sv
      - logic/data_ram.sv
      - logic/writeback.sv
      - logic/reg_file.sv
      - logic/backend_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/backend_chk.sv
      - sim/backend_tb.sv

//--- sim/backend_tb.sv
`timescale 1ns/100ps
`include "backend_config.svh"

module backend_tb
    import cpu_types_pkg::*, mem_ctrl_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     ex_valid;
    mem_op_t  ex_op;
    word_t    ex_result;
    word_t    ex_store_data;
    reg_idx_t ex_rd;
    logic     ex_reg_write;
    logic     stall;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    reg_idx_t rd_addr;
    word_t    rd_data;

    int        value_errors = 0;
    int        other_errors = 0;
    int        cycle = 0;
    int        n_lines = 0;
    logic [31:0] lfsr = 32'd80;

    // One entry per test line
    byte      t_op [$];
    reg_idx_t t_rd [$];
    logic     t_rw [$];
    word_t    t_res [$];
    word_t    t_sd [$];
    logic     t_has_exp [$];
    word_t    t_exp [$];

    // Writes the DUT still owes, in order
    reg_idx_t q_rd [$];
    word_t    q_data [$];
    int       q_cycle [$];

    word_t reg_model [`REG_COUNT];
    word_t ram_model [int];

    backend_top i_backend_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int b = 0; b < `XLEN; b++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            w = {w[`XLEN-2:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic load_tests();
        int    fd;
        string line;
        string op_s;
        string exp_s;
        int    rd_v;
        int    rw_v;
        word_t res_v;
        word_t sd_v;
        word_t exp_v;
        fd = $fopen("sim/backend_tests.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open the test file sim/backend_tests.txt");
        end
        else
        begin
            while ($fgets(line, fd))
            begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                void'($sscanf(line, "%s %h %h %h %h %s", op_s, rd_v, rw_v, res_v, sd_v, exp_s));
                if (op_s == "R")
                    res_v = random_word();  // Filler with random result
                t_op.push_back(op_s[0]);
                t_rd.push_back(reg_idx_t'(rd_v));
                t_rw.push_back(rw_v[0]);
                t_res.push_back(res_v);
                t_sd.push_back(sd_v);
                t_has_exp.push_back(exp_s != "-");
                exp_v = '0;
                if (exp_s != "-")
                    void'($sscanf(exp_s, "%h", exp_v));
                t_exp.push_back(exp_v);
            end
            $fclose(fd);
            n_lines = t_op.size();
        end
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < `REG_COUNT; r++)
        begin
            @(posedge clk);
            rd_addr <= reg_idx_t'(r);
            @(negedge clk);
            check($sformatf("rd_data of x%0d", r), rd_data, reg_model[r]);
        end
    endtask

    // Writeback monitor sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst && wb_en)
        begin
            if (q_rd.size() == 0)
            begin
                other_errors++;
                $display("At %0t ns wb_en went high although no write was expected", $time);
            end
            else
            begin
                check("wb_rd", word_t'(wb_rd), word_t'(q_rd.pop_front()));
                check("wb_data", wb_data, q_data.pop_front());
                check("wb_en cycle", word_t'(cycle), word_t'(q_cycle.pop_front()));
            end
        end
    end

    initial
    begin
        wait (n_lines > 0);
        repeat (16 + n_lines * (`RAM_WAIT + 10) + 4 * `REG_COUNT) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        word_t   value;
        int      addr;
        int      stall_len;
        mem_op_t op;
        clk = 0;
        rst = 1;
        ex_valid = 0;
        ex_op = MEM_NONE;
        ex_result = '0;
        ex_store_data = '0;
        ex_rd = '0;
        ex_reg_write = 0;
        rd_addr = '0;
        foreach (reg_model[r])
            reg_model[r] = '0;
        load_tests();
        repeat (16) @(posedge clk);
        rst <= 0;
        @(negedge clk);
        check("stall after reset", word_t'(stall), '0);
        check("wb_en after reset", word_t'(wb_en), '0);
        read_all_regs();

        for (int i = 0; i < n_lines; i++)
        begin
            @(posedge clk);
            op = (t_op[i] == "L") ? MEM_LOAD : (t_op[i] == "S") ? MEM_STORE : MEM_NONE;
            ex_valid      <= 1;
            ex_op         <= op;
            ex_result     <= t_res[i];
            ex_store_data <= t_sd[i];
            ex_rd         <= t_rd[i];
            ex_reg_write  <= t_rw[i];
            addr  = t_res[i][$bits(ram_addr_t)+1:2];
            value = t_res[i];
            if (op == MEM_STORE)
                ram_model[addr] = t_sd[i];
            else if (op == MEM_LOAD)
            begin
                if (!ram_model.exists(addr))
                begin
                    other_errors++;
                    $display("Test line %0d loads a word that was never stored", i);
                end
                else
                    value = ram_model[addr];
            end
            if (t_has_exp[i])
                check($sformatf("model value of line %0d", i), value, t_exp[i]);
            if (op != MEM_STORE && t_rw[i] && t_rd[i] != '0)
            begin
                reg_model[t_rd[i]] = value;
                q_rd.push_back(t_rd[i]);
                q_data.push_back(value);
                q_cycle.push_back(cycle + ((op == MEM_NONE) ? 3 : `RAM_WAIT + 4));
            end
            if (op != MEM_NONE)
            begin
                @(posedge clk);
                ex_valid <= 0;
                @(negedge clk);
                stall_len = 0;
                while (stall)
                begin
                    stall_len++;
                    @(negedge clk);
                end
                check("stall length", word_t'(stall_len), word_t'(`RAM_WAIT + 1));
            end
        end
        @(posedge clk);
        ex_valid <= 0;
        repeat (`RAM_WAIT + 6) @(posedge clk);
        if (q_rd.size() != 0)
        begin
            other_errors++;
            $display("%0d expected register writes never happened", q_rd.size());
        end
        read_all_regs();
        other_errors += i_backend_top.i_backend_chk.fail_count;

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim/backend_chk.sv
`timescale 1ns/100ps

module backend_chk
    import cpu_types_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     ex_valid,
    input logic     stall,
    input logic     wb_en,
    input reg_idx_t wb_rd
);

    int fail_count = 0;  // Read by the testbench at the end

    // Register zero never written
    assert property (@(posedge clk) disable iff (rst) wb_en |-> (wb_rd != '0))
    else
    begin
        fail_count++;
        $error("wb_en high for register zero");
    end

    // Execute side respects the stall
    assert property (@(posedge clk) disable iff (rst) ex_valid |-> !stall)
    else
    begin
        fail_count++;
        $error("ex_valid while stall is high");
    end

endmodule

bind backend_top backend_chk i_backend_chk
(
    .clk      (clk),
    .rst      (rst),
    .ex_valid (ex_valid),
    .stall    (stall),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd)
);

//--- logic/backend_top.sv
`timescale 1ns/100ps

module backend_top
    import cpu_types_pkg::*, mem_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // Execute side
    input  logic     ex_valid,
    input  mem_op_t  ex_op,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  reg_idx_t ex_rd,
    input  logic     ex_reg_write,
    output logic     stall,

    // Writeback observation
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,

    // Register read port
    input  reg_idx_t rd_addr,
    output word_t    rd_data
);

    logic      ram_req;
    logic      ram_we;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    logic      ram_done;
    word_t     ram_rdata;

    stage_if mem_wb ();

    mem_stage i_mem_stage
    (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .stall         (stall),
        .ram_req       (ram_req),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_done      (ram_done),
        .ram_rdata     (ram_rdata),
        .wb            (mem_wb.source)
    );

    data_ram i_data_ram
    (
        .clk   (clk),
        .rst   (rst),
        .req   (ram_req),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .done  (ram_done),
        .rdata (ram_rdata)
    );

    writeback i_writeback
    (
        .clk     (clk),
        .rst     (rst),
        .in_item (mem_wb.sink),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    reg_file i_reg_file
    (
        .clk   (clk),
        .rst   (rst),
        .we    (wb_en),
        .waddr (wb_rd),
        .wdata (wb_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps
`include "backend_config.svh"

module reg_file
    import cpu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr,
    output word_t    rdata
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is hardwired on the read side
    always_comb
    begin
        if (raddr == '0)
            rdata = '0;
        else
            rdata = regs[raddr];
    end

endmodule

//--- logic/writeback.sv
`timescale 1ns/100ps

module writeback
    import cpu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    stage_if.sink    in_item,

    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    logic write_ok;

    // Register zero is never written
    assign write_ok = in_item.valid && in_item.reg_write && (in_item.rd != '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_en <= 1'b0;
        end
        else
        begin
            wb_en <= write_ok;  // High for one cycle at most
        end
    end

    // Destination and data only move with a valid item
    always_ff @(posedge clk)
    begin
        if (in_item.valid)
        begin
            wb_rd <= in_item.rd;
            if (in_item.from_mem)
                wb_data <= in_item.mem_data;    // Load result
            else
                wb_data <= in_item.alu_result;
        end
    end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/100ps
`include "backend_config.svh"

module data_ram
    import cpu_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      we,
    input  ram_addr_t addr,
    input  word_t     wdata,
    output logic      done,
    output word_t     rdata
);

    localparam int CNT_W = $clog2(`RAM_WAIT + 1);

    word_t            mem [`RAM_DEPTH];
    logic [CNT_W-1:0] wait_cnt;  // Cycles left until done, zero when idle

    // Storage, the write lands right at the request
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];  // Held until the next request
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wait_cnt <= '0;
        end
        else if (req)
        begin
            wait_cnt <= CNT_W'(`RAM_WAIT);
        end
        else if (wait_cnt != '0)
        begin
            wait_cnt <= wait_cnt - CNT_W'(1);
        end
    end

    // Last counted cycle, RAM_WAIT cycles after req
    assign done = (wait_cnt == CNT_W'(1));

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import cpu_types_pkg::*, mem_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      ex_valid,
    input  mem_op_t   ex_op,
    input  word_t     ex_result,      // ALU result, byte address for memory ops
    input  word_t     ex_store_data,
    input  reg_idx_t  ex_rd,
    input  logic      ex_reg_write,

    output logic      stall,

    output logic      ram_req,
    output logic      ram_we,
    output ram_addr_t ram_addr,
    output word_t     ram_wdata,
    input  logic      ram_done,
    input  word_t     ram_rdata,

    stage_if.source   wb
);

    mem_state_t state;
    logic       accept;

    // New items are only taken while idle
    assign accept = ex_valid && (state == ST_IDLE);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            stall    <= 1'b0;
            ram_req  <= 1'b0;
            wb.valid <= 1'b0;
        end
        else
        begin
            ram_req  <= 1'b0;  // Both are single-cycle pulses
            wb.valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (ex_valid)
                    begin
                        if (ex_op == MEM_NONE)
                        begin
                            wb.valid <= 1'b1;  // Straight through
                        end
                        else
                        begin
                            ram_req <= 1'b1;
                            stall   <= 1'b1;
                            state   <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT:
                begin
                    // Release in the cycle after done
                    if (ram_done)
                    begin
                        wb.valid <= 1'b1;
                        stall    <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Item payload and RAM request fields
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wb.alu_result <= ex_result;
            wb.rd         <= ex_rd;
            wb.reg_write  <= ex_reg_write && (ex_op != MEM_STORE);
            wb.from_mem   <= (ex_op == MEM_LOAD);
            ram_we        <= (ex_op == MEM_STORE);
            ram_addr      <= ex_result[$bits(ram_addr_t)+1:2];  // Byte to word address
            ram_wdata     <= ex_store_data;
        end
        if (ram_done)
            wb.mem_data <= ram_rdata;
    end

endmodule

//--- logic/stage_if.sv
`timescale 1ns/100ps

interface stage_if
    import cpu_types_pkg::*;
();

    logic      valid;      // One cycle per item
    logic      from_mem;   // Load result sits in mem_data
    word_t     mem_data;
    word_t     alu_result;
    reg_idx_t  rd;
    logic      reg_write;  // Already low for stores

    modport source
    (
        output valid,
        output from_mem,
        output mem_data,
        output alu_result,
        output rd,
        output reg_write
    );

    modport sink
    (
        input valid,
        input from_mem,
        input mem_data,
        input alu_result,
        input rd,
        input reg_write
    );

endinterface

//--- logic/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // Memory operation carried by an execute item
    typedef enum logic [1:0]
    {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    // Memory stage FSM
    typedef enum logic
    {
        ST_IDLE, // Accepting items
        ST_WAIT  // RAM access in flight, stall held
    } mem_state_t;

endpackage

//--- logic/cpu_types_pkg.sv
`include "backend_config.svh"

package cpu_types_pkg;

    // One datapath word
    typedef logic [`XLEN-1:0] word_t;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Word address into the data RAM
    typedef logic [7:0] ram_addr_t;

endpackage

//--- logic/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// Datapath width in bits
`define XLEN 32

// Architectural registers, register zero included
`define REG_COUNT 32

// Data RAM size in words
`define RAM_DEPTH 256

// Cycles from a RAM request to its done pulse, at least 1
`define RAM_WAIT 2

`endif
